// ==== common/rv_pkg.sv ====
////////////////////////////////////////////////////////////
// shared definitions for the RV32I subset test system:
// opcodes, instruction word union, ALU ops, FSM encodings,
// memory map and test register constants
////////////////////////////////////////////////////////////
`default_nettype none

package rv_pkg;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // memory map
    localparam int          RAM_ADDR_WIDTH  = 12;
    localparam logic [31:0] BOOT_ADDR       = 32'h0000_0080;
    localparam logic [31:0] TEST_CTRL_ADDR  = 32'h2000_0000;
    localparam logic [31:0] EXIT_ADDR       = 32'h2000_0004;
    localparam logic [31:0] TEST_PASS_VALUE = 32'd123456789;

    // core FSM encodings
    localparam logic [2:0] ST_FETCH      = 3'd0;
    localparam logic [2:0] ST_WAIT_INSTR = 3'd1;
    localparam logic [2:0] ST_EXECUTE    = 3'd2;
    localparam logic [2:0] ST_DATA_REQ   = 3'd3;
    localparam logic [2:0] ST_WAIT_DATA  = 3'd4;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS_B,
        ALU_EQ
    } alu_op_e;

    // one instruction word, seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

endpackage

`default_nettype wire

// ==== core/rv_decoder.sv ====
////////////////////////////////////////////////////////////
// instruction decoder: control fields and sign-extended
// immediate for LUI, ADDI, ADD, SUB, LW, SW, BEQ, BNE, JAL
////////////////////////////////////////////////////////////
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  rv_instr_u   instr_i,
    output alu_op_e     alu_op_o,
    output logic [31:0] imm_o,
    output logic        use_imm_o,
    output logic        reg_we_o,
    output logic        is_load_o,
    output logic        is_store_o,
    output logic        is_branch_o,
    output logic        branch_ne_o,
    output logic        is_jal_o
);

    always_comb begin
        // anything not matched below stays a no-op
        alu_op_o    = ALU_ADD;
        imm_o       = '0;
        use_imm_o   = 1'b0;
        reg_we_o    = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        branch_ne_o = 1'b0;
        is_jal_o    = 1'b0;

        case (instr_i.r.opcode)
            OPC_LUI: begin
                alu_op_o  = ALU_PASS_B;
                imm_o     = {instr_i.u.imm, 12'b0};
                use_imm_o = 1'b1;
                reg_we_o  = 1'b1;
            end
            OPC_JAL: begin
                imm_o    = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                            instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
                reg_we_o = 1'b1;
                is_jal_o = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o    = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                            instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
                alu_op_o = ALU_EQ;
                // funct3 000 is BEQ, 001 is BNE
                is_branch_o = (instr_i.b.funct3[2:1] == 2'b00);
                branch_ne_o = instr_i.b.funct3[0];
            end
            OPC_LOAD: begin
                imm_o     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                use_imm_o = 1'b1;
                reg_we_o  = (instr_i.i.funct3 == 3'b010);
                is_load_o = (instr_i.i.funct3 == 3'b010);
            end
            OPC_STORE: begin
                imm_o      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
                use_imm_o  = 1'b1;
                is_store_o = (instr_i.s.funct3 == 3'b010);
            end
            OPC_OP_IMM: begin
                imm_o     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
                use_imm_o = 1'b1;
                reg_we_o  = (instr_i.i.funct3 == 3'b000);
            end
            OPC_OP: begin
                // only ADD and SUB, both funct3 000
                alu_op_o = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
                reg_we_o = (instr_i.r.funct3 == 3'b000) &&
                           (instr_i.r.funct7 == 7'h00 || instr_i.r.funct7 == 7'h20);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== core/rv_regfile.sv ====
////////////////////////////////////////////////////////////
// 32 x 32-bit register file, two read ports, one write
////////////////////////////////////////////////////////////
`default_nettype none

module rv_regfile (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic [4:0]  raddr_a_i,
    input  wire logic [4:0]  raddr_b_i,
    output logic [31:0]      rdata_a_o,
    output logic [31:0]      rdata_b_o,
    input  wire logic        we_i,
    input  wire logic [4:0]  waddr_i,
    input  wire logic [31:0] wdata_i
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs[raddr_b_i];

endmodule

`default_nettype wire

// ==== core/rv_core.sv ====
////////////////////////////////////////////////////////////
// multi-cycle RV32I subset core: fetch/execute/memory FSM
// with instruction and data bus masters
////////////////////////////////////////////////////////////
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        fetch_enable_i,

    output logic             instr_req_o,
    input  wire logic        instr_gnt_i,
    input  wire logic        instr_rvalid_i,
    output logic [31:0]      instr_addr_o,
    input  wire logic [31:0] instr_rdata_i,

    output logic             data_req_o,
    input  wire logic        data_gnt_i,
    input  wire logic        data_rvalid_i,
    output logic             data_we_o,
    output logic [3:0]       data_be_o,
    output logic [31:0]      data_addr_o,
    output logic [31:0]      data_wdata_o,
    input  wire logic [31:0] data_rdata_i
);

    logic [2:0]  state_q;
    logic [31:0] pc_q;
    rv_instr_u   instr_q;

    alu_op_e     alu_op;
    logic [31:0] imm;
    logic        use_imm;
    logic        reg_we;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        branch_ne;
    logic        is_jal;

    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] pc_plus4;
    logic        take_jump;
    logic        rf_we;
    logic [31:0] rf_wdata;

    rv_decoder decoder_i (
        .instr_i     ( instr_q   ),
        .alu_op_o    ( alu_op    ),
        .imm_o       ( imm       ),
        .use_imm_o   ( use_imm   ),
        .reg_we_o    ( reg_we    ),
        .is_load_o   ( is_load   ),
        .is_store_o  ( is_store  ),
        .is_branch_o ( is_branch ),
        .branch_ne_o ( branch_ne ),
        .is_jal_o    ( is_jal    )
    );

    rv_regfile regfile_i (
        .clk_i     ( clk_i          ),
        .rst_n_i   ( rst_n_i        ),
        .raddr_a_i ( instr_q.r.rs1  ),
        .raddr_b_i ( instr_q.r.rs2  ),
        .rdata_a_o ( rdata_a        ),
        .rdata_b_o ( rdata_b        ),
        .we_i      ( rf_we          ),
        .waddr_i   ( instr_q.r.rd   ),
        .wdata_i   ( rf_wdata       )
    );

    always_comb begin
        op_b = use_imm ? imm : rdata_b;
        case (alu_op)
            ALU_ADD:    alu_result = rdata_a + op_b;
            ALU_SUB:    alu_result = rdata_a - op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = {31'd0, rdata_a == op_b};
        endcase
    end

    assign pc_plus4  = pc_q + 32'd4;
    // equality result sits in bit 0, BNE inverts it
    assign take_jump = is_jal || (is_branch && (alu_result[0] ^ branch_ne));

    // ALU results retire in execute, load data on its response
    assign rf_we    = (state_q == ST_EXECUTE && reg_we && !is_load) ||
                      (state_q == ST_WAIT_DATA && data_rvalid_i && is_load);
    assign rf_wdata = (state_q == ST_WAIT_DATA) ? data_rdata_i :
                      is_jal                   ? pc_plus4     : alu_result;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_FETCH;
            pc_q    <= BOOT_ADDR;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (instr_req_o && instr_gnt_i) state_q <= ST_WAIT_INSTR;
                end
                ST_WAIT_INSTR: begin
                    if (instr_rvalid_i) state_q <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    pc_q    <= take_jump ? pc_q + imm : pc_plus4;
                    state_q <= (is_load || is_store) ? ST_DATA_REQ : ST_FETCH;
                end
                ST_DATA_REQ: begin
                    if (data_gnt_i) state_q <= ST_WAIT_DATA;
                end
                ST_WAIT_DATA: begin
                    if (data_rvalid_i) state_q <= ST_FETCH;
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_WAIT_INSTR && instr_rvalid_i) instr_q <= instr_rdata_i;
    end

    assign instr_req_o  = (state_q == ST_FETCH) && fetch_enable_i;
    assign instr_addr_o = pc_q;

    // address and store data stay stable, instr_q and regs do not change here
    assign data_req_o   = (state_q == ST_DATA_REQ);
    assign data_we_o    = is_store;
    assign data_be_o    = 4'b1111;
    assign data_addr_o  = alu_result;
    assign data_wdata_o = rdata_b;

endmodule

`default_nettype wire

// ==== mm_ram/mm_ram.sv ====
////////////////////////////////////////////////////////////
// word RAM with program load port, instruction and data
// bus slaves, memory-mapped test control and exit registers
////////////////////////////////////////////////////////////
`default_nettype none

module mm_ram import rv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,

    input  wire logic                      load_we_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0] load_addr_i,
    input  wire logic [31:0]               load_data_i,

    input  wire logic                      instr_req_i,
    input  wire logic [31:0]               instr_addr_i,
    output logic                           instr_gnt_o,
    output logic                           instr_rvalid_o,
    output logic [31:0]                    instr_rdata_o,

    input  wire logic                      data_req_i,
    input  wire logic [31:0]               data_addr_i,
    input  wire logic                      data_we_i,
    input  wire logic [3:0]                data_be_i,
    input  wire logic [31:0]               data_wdata_i,
    output logic                           data_gnt_o,
    output logic                           data_rvalid_o,
    output logic [31:0]                    data_rdata_o,

    output logic                           tests_passed_o,
    output logic                           tests_failed_o,
    output logic                           exit_valid_o,
    output logic [31:0]                    exit_value_o
);

    logic [31:0] mem [2**(RAM_ADDR_WIDTH-2)];

    logic [RAM_ADDR_WIDTH-3:0] load_idx;
    logic [RAM_ADDR_WIDTH-3:0] instr_idx;
    logic [RAM_ADDR_WIDTH-3:0] data_idx;
    logic                      data_ram_sel;
    logic                      data_wr;

    assign load_idx     = load_addr_i[RAM_ADDR_WIDTH-1:2];
    assign instr_idx    = instr_addr_i[RAM_ADDR_WIDTH-1:2];
    assign data_idx     = data_addr_i[RAM_ADDR_WIDTH-1:2];
    assign data_ram_sel = (data_addr_i[31:RAM_ADDR_WIDTH] == '0);
    assign data_wr      = data_req_i && data_we_i;

    // no back-pressure
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    // the load port only runs while the core is held
    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_idx] <= load_data_i;
        end else if (data_wr && data_ram_sel) begin
            for (int b = 0; b < 4; b++) begin
                if (data_be_i[b]) mem[data_idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_req_i) instr_rdata_o <= mem[instr_idx];
        // test registers read as zero
        if (data_req_i && !data_we_i) data_rdata_o <= data_ram_sel ? mem[data_idx] : 32'd0;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
            exit_valid_o   <= data_wr && (data_addr_i == EXIT_ADDR);
            if (data_wr && data_addr_i == EXIT_ADDR) exit_value_o <= data_wdata_i;
            // verdict flags are sticky until reset
            if (data_wr && data_addr_i == TEST_CTRL_ADDR) begin
                if (data_wdata_i == TEST_PASS_VALUE) tests_passed_o <= 1'b1;
                else tests_failed_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_wrapper.sv ====
////////////////////////////////////////////////////////////
// top level: core and memory with test registers
////////////////////////////////////////////////////////////
`default_nettype none

module rv_wrapper import rv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      fetch_enable_i,
    input  wire logic                      load_we_i,
    input  wire logic [RAM_ADDR_WIDTH-1:0] load_addr_i,
    input  wire logic [31:0]               load_data_i,
    output logic                           tests_passed_o,
    output logic                           tests_failed_o,
    output logic                           exit_valid_o,
    output logic [31:0]                    exit_value_o
);

    // core to memory buses
    logic        instr_req;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_addr;
    logic [31:0] instr_rdata;

    logic        data_req;
    logic        data_gnt;
    logic        data_rvalid;
    logic        data_we;
    logic [3:0]  data_be;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;

    rv_core core_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req      ),
        .instr_gnt_i    ( instr_gnt      ),
        .instr_rvalid_i ( instr_rvalid   ),
        .instr_addr_o   ( instr_addr     ),
        .instr_rdata_i  ( instr_rdata    ),
        .data_req_o     ( data_req       ),
        .data_gnt_i     ( data_gnt       ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_we_o      ( data_we        ),
        .data_be_o      ( data_be        ),
        .data_addr_o    ( data_addr      ),
        .data_wdata_o   ( data_wdata     ),
        .data_rdata_i   ( data_rdata     )
    );

    mm_ram ram_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .load_we_i      ( load_we_i      ),
        .load_addr_i    ( load_addr_i    ),
        .load_data_i    ( load_data_i    ),
        .instr_req_i    ( instr_req      ),
        .instr_addr_i   ( instr_addr     ),
        .instr_gnt_o    ( instr_gnt      ),
        .instr_rvalid_o ( instr_rvalid   ),
        .instr_rdata_o  ( instr_rdata    ),
        .data_req_i     ( data_req       ),
        .data_addr_i    ( data_addr      ),
        .data_we_i      ( data_we        ),
        .data_be_i      ( data_be        ),
        .data_wdata_i   ( data_wdata     ),
        .data_gnt_o     ( data_gnt       ),
        .data_rvalid_o  ( data_rvalid    ),
        .data_rdata_o   ( data_rdata     ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// 4 ns clock and 5-cycle reset, repeated on request
////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock_gen (
    input  wire logic reset_req_i,
    output logic      clk_o,
    output logic      rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset at power-up, then again whenever reset_req_i is seen at a rising edge
    initial begin
        rst_n_o = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(posedge clk_o);
            #1 rst_n_o = 1'b1;
            do begin
                @(posedge clk_o);
            end while (!reset_req_i);
            #1 rst_n_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_rv_wrapper.sv ====
////////////////////////////////////////////////////////////
// testbench for rv_wrapper: test table, instruction
// encoders, LFSR operands, program loader, checks, timeout
////////////////////////////////////////////////////////////
`default_nettype none

module tb_rv_wrapper import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // program kinds
    localparam int K_ARITH  = 0;
    localparam int K_MEM    = 1;
    localparam int K_BRANCH = 2;
    localparam int K_JAL    = 3;
    localparam int K_PASS   = 4;
    localparam int K_FAIL   = 5;

    localparam int NUM_ROWS     = 8;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_PROG_LEN = 10;
    localparam int CYCLE_LIMIT  = NUM_ROWS * (MAX_PROG_LEN + 60 * 5) +
                                  (NUM_ROWS + 1) * RESET_CYCLES;
    localparam int EXIT_OFS     = int'(EXIT_ADDR - TEST_CTRL_ADDR);

    localparam int ROW_KIND [NUM_ROWS] = '{K_ARITH, K_MEM, K_BRANCH, K_JAL,
                                           K_PASS, K_FAIL, K_ARITH, K_BRANCH};

    logic                      clk;
    logic                      rst_n;
    logic                      reset_req;
    logic                      fetch_enable;
    logic                      load_we;
    logic [RAM_ADDR_WIDTH-1:0] load_addr;
    logic [31:0]               load_data;
    logic                      tests_passed;
    logic                      tests_failed;
    logic                      exit_valid;
    logic [31:0]               exit_value;

    // operands, expected exit value and expected {passed, failed} per row
    logic [31:0] row_a     [NUM_ROWS];
    logic [31:0] row_b     [NUM_ROWS];
    logic [31:0] row_exp   [NUM_ROWS];
    logic [1:0]  row_flags [NUM_ROWS];

    logic [31:0] lfsr_q;
    logic [31:0] prog [$];
    int          cycles = 0;

    tb_clock_gen clock_gen_i (
        .reset_req_i ( reset_req ),
        .clk_o       ( clk       ),
        .rst_n_o     ( rst_n     )
    );

    rv_wrapper rv_wrapper_i (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .load_we_i      ( load_we      ),
        .load_addr_i    ( load_addr    ),
        .load_data_i    ( load_data    ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] lui_word(int rd, int imm);
        return {imm[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] addi_word(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lw_word(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
    endfunction

    function automatic logic [31:0] sw_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] add_word(int rd, int rs1, int rs2);
        return {7'h00, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] sub_word(int rd, int rs1, int rs2);
        return {7'h20, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP};
    endfunction

    // funct3 000 for BEQ, 001 for BNE
    function automatic logic [31:0] branch_word(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic report_error(string msg);
        $display("Fail %0d ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_idle();
        assert (!exit_valid && !tests_passed && !tests_failed && exit_value == 32'd0)
            else report_error("outputs not idle during reset or program load");
    endtask

    task automatic fill_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            row_a[r]     = '0;
            row_b[r]     = '0;
            row_flags[r] = 2'b00;
            case (ROW_KIND[r])
                K_ARITH: begin
                    row_a[r]   = rand_bits(11);
                    row_b[r]   = rand_bits(11);
                    row_exp[r] = row_b[r] << 1;
                end
                K_MEM: begin
                    row_a[r]   = rand_bits(32);
                    row_exp[r] = row_a[r] + 32'd1;
                end
                K_BRANCH: begin
                    row_a[r] = rand_bits(4);
                    if (row_a[r] == 32'd0) row_a[r] = 32'd1;
                    row_b[r]   = rand_bits(11);
                    row_exp[r] = row_a[r] * row_b[r];
                end
                K_JAL: begin
                    // link register holds the address of the word after the JAL
                    row_a[r]   = rand_bits(20);
                    row_exp[r] = (row_a[r] << 12) + BOOT_ADDR + 32'd12;
                end
                K_PASS: begin
                    row_a[r]     = TEST_PASS_VALUE;
                    row_exp[r]   = 32'd0;
                    row_flags[r] = 2'b10;
                end
                default: begin
                    row_a[r] = rand_bits(32);
                    if (row_a[r] == TEST_PASS_VALUE) row_a[r] = row_a[r] ^ 32'd1;
                    row_exp[r]   = 32'd0;
                    row_flags[r] = 2'b01;
                end
            endcase
        end
    endtask

    task automatic build_program(int kind, logic [31:0] a, logic [31:0] b);
        prog.delete();
        // x10 points at the test registers
        prog.push_back(lui_word(10, TEST_CTRL_ADDR >> 12));
        case (kind)
            K_ARITH: begin
                prog.push_back(addi_word(1, 0, a));
                prog.push_back(addi_word(2, 0, b));
                prog.push_back(add_word(3, 1, 2));
                prog.push_back(sub_word(4, 1, 2));
                prog.push_back(sub_word(5, 3, 4));
                prog.push_back(sw_word(5, 10, EXIT_OFS));
            end
            K_MEM: begin
                // upper part rounded so the sign-extended low part adds back
                prog.push_back(lui_word(1, (a + 32'h800) >> 12));
                prog.push_back(addi_word(1, 1, a));
                prog.push_back(addi_word(6, 0, 32'h400));
                prog.push_back(sw_word(1, 6, 0));
                prog.push_back(lw_word(7, 6, 0));
                prog.push_back(addi_word(7, 7, 1));
                prog.push_back(sw_word(7, 10, EXIT_OFS));
            end
            K_BRANCH: begin
                prog.push_back(addi_word(1, 0, a));
                prog.push_back(addi_word(3, 0, b));
                prog.push_back(add_word(2, 2, 3));
                prog.push_back(addi_word(1, 1, -1));
                prog.push_back(branch_word(1, 1, 0, -8));
                prog.push_back(branch_word(0, 0, 0, 8));
                // poison instruction that the BEQ skips
                prog.push_back(addi_word(2, 2, 1));
                prog.push_back(sw_word(2, 10, EXIT_OFS));
            end
            K_JAL: begin
                prog.push_back(lui_word(1, a));
                prog.push_back(jal_word(5, 8));
                prog.push_back(addi_word(1, 1, 1));
                prog.push_back(add_word(6, 1, 5));
                prog.push_back(sw_word(6, 10, EXIT_OFS));
            end
            default: begin
                prog.push_back(lui_word(1, (a + 32'h800) >> 12));
                prog.push_back(addi_word(1, 1, a));
                prog.push_back(sw_word(1, 10, 0));
                prog.push_back(sw_word(0, 10, EXIT_OFS));
            end
        endcase
        // park the core on a jump to itself
        prog.push_back(jal_word(0, 0));
    endtask

    task automatic run_row(int r);
        logic [31:0] addr;
        build_program(ROW_KIND[r], row_a[r], row_b[r]);
        reset_req = 1'b1;
        @(negedge rst_n);
        reset_req = 1'b0;
        do begin
            @(negedge clk);
            check_idle();
        end while (!rst_n);
        @(posedge clk);
        #1;
        foreach (prog[w]) begin
            addr      = BOOT_ADDR + 32'(4 * w);
            load_we   = 1'b1;
            load_addr = addr[RAM_ADDR_WIDTH-1:0];
            load_data = prog[w];
            @(negedge clk);
            check_idle();
            @(posedge clk);
            #1;
        end
        load_we      = 1'b0;
        fetch_enable = 1'b1;
        do begin
            @(negedge clk);
        end while (!exit_valid);
        assert (exit_value == row_exp[r])
            else report_error($sformatf("row %0d exit value %h, expected %h",
                                        r, exit_value, row_exp[r]));
        assert ({tests_passed, tests_failed} == row_flags[r])
            else report_error($sformatf("row %0d flags passed=%b failed=%b, expected %b",
                                        r, tests_passed, tests_failed, row_flags[r]));
        @(negedge clk);
        assert (!exit_valid) else report_error("exit_valid_o high for more than one cycle");
        @(posedge clk);
        #1;
        fetch_enable = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: exit_valid_o never came within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        reset_req    = 1'b0;
        fetch_enable = 1'b0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        lfsr_q       = 32'hfacf;
        fill_table();
        @(posedge rst_n);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
common/rv_pkg.sv
core/rv_decoder.sv
core/rv_regfile.sv
core/rv_core.sv
mm_ram/mm_ram.sv
logic/rv_wrapper.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_wrapper testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --assert --top-module tb_rv_wrapper -f sim.f \
    --Mdir obj_dir -o tb_rv_wrapper
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_wrapper
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
